// File: vlog.f
+incdir+hw
hw/cg_pkg.sv
hw/cg_fifo.sv
hw/cg_dot_producer.sv
hw/cg_alpha_divider.sv
hw/cg_update_consumer.sv
hw/cg_step_top.sv
sim/cg_step_sva.sv
sim/cg_step_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f vlog.f --top-module cg_step_tb \
	-Mdir obj_dir -o cg_step_sim \
	&& ./obj_dir/cg_step_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "run finished: success" \
	|| { echo "run finished: failure"; exit 1; }

exit 0

// File: sim/cg_step_tb.sv
`default_nettype none

`include "cg_params.svh"

module cg_step_tb
	import cg_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	// 4 idle singles, 1 zero-ap, 6 back to back, 4 with gaps
	localparam int NUM_VEC = 15;
	localparam longint WATCHDOG_NS = NUM_VEC * (`CG_N + 80) * 100;

	typedef struct packed {
		fix_t x_new;
		fix_t r_new;
		logic zero;
		logic last;
	} exp_beat_t;

	logic clk;
	logic reset;
	logic in_valid;
	cg_elem_t in_elem;
	logic busy;
	logic out_valid;
	cg_out_t out_elem;
	logic out_last;
	logic zero_div;

	logic [31:0] seed;
	exp_beat_t exp_q [$];
	int last_count;

	cg_step_top u_dut (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_elem(in_elem),
		.busy(busy),
		.out_valid(out_valid),
		.out_elem(out_elem),
		.out_last(out_last),
		.zero_div(zero_div)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// uniform in -4.0 .. +4.0
	function automatic fix_t rand_fix();
		logic [31:0] u;
		u = (lcg_next() >> 8) % 32'd524289;
		return fix_t'(u) - fix_t'(262144);
	endfunction

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns: %s got %0h, expected %0h", $time, what, actual, expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	// reference fixed-point step for one vector
	function automatic void queue_expected(input cg_elem_t vec [`CG_N]);
		longint sum_rr;
		longint sum_pap;
		longint num;
		fix_t rr;
		fix_t pap;
		fix_t alpha;
		exp_beat_t e;
		sum_rr = 0;
		sum_pap = 0;
		for (int i = 0; i < `CG_N; i++)
		begin
			sum_rr += longint'(vec[i].r) * longint'(vec[i].r);
			sum_pap += longint'(vec[i].p) * longint'(vec[i].ap);
		end
		rr = fix_t'(sum_rr >>> `CG_FRAC);
		pap = fix_t'(sum_pap >>> `CG_FRAC);
		if (pap == '0)
			alpha = '0;
		else
		begin
			num = longint'(rr) <<< `CG_FRAC;
			alpha = fix_t'(num / longint'(pap));
		end
		for (int i = 0; i < `CG_N; i++)
		begin
			e.x_new = fix_t'(longint'(vec[i].x)
				+ ((longint'(alpha) * longint'(vec[i].p)) >>> `CG_FRAC));
			e.r_new = fix_t'(longint'(vec[i].r)
				- ((longint'(alpha) * longint'(vec[i].ap)) >>> `CG_FRAC));
			e.zero = (pap == '0);
			e.last = (i == `CG_N - 1);
			exp_q.push_back(e);
		end
	endfunction

	// called on a falling edge, returns on one
	task automatic send_vector(input bit zero_ap, input int max_gap);
		cg_elem_t vec [`CG_N];
		int gap;
		for (int i = 0; i < `CG_N; i++)
		begin
			vec[i].x = rand_fix();
			vec[i].r = rand_fix();
			vec[i].p = rand_fix();
			vec[i].ap = zero_ap ? fix_t'(0) : rand_fix();
		end
		while (busy)
			@(negedge clk);
		for (int i = 0; i < `CG_N; i++)
		begin
			in_valid = 1'b1;
			in_elem = vec[i];
			if (i == `CG_N - 1)
				queue_expected(vec);
			@(negedge clk);
			in_valid = 1'b0;
			gap = (max_gap > 0) ? int'((lcg_next() >> 16) % (max_gap + 1)) : 0;
			repeat (gap)
				@(negedge clk);
		end
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0)
			@(negedge clk);
		@(negedge clk);
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		exp_beat_t e;
		if (!reset && out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("unexpected output beat at %0t ns while no vector was pending", $time);
				$display("SOME TESTS FAILED");
				$fatal(1, "unexpected output beat");
			end
			else
			begin
				e = exp_q.pop_front();
				check_value(out_elem.x_new, e.x_new, "x_new");
				check_value(out_elem.r_new, e.r_new, "r_new");
				check_value(zero_div, e.zero, "zero_div");
				check_value(out_last, e.last, "out_last");
				if (out_last)
					last_count++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired: outputs stalled with %0d beats still pending", exp_q.size());
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation timed out");
	end

	initial
	begin
		seed = 32'd47;
		last_count = 0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_elem = '0;
		repeat (5)
			@(negedge clk);
		reset = 1'b0;
		// quiet outputs before any vector
		repeat (3)
		begin
			@(negedge clk);
			check_value(busy, 1'b0, "busy after reset");
			check_value(out_valid, 1'b0, "out_valid after reset");
			check_value(zero_div, 1'b0, "zero_div after reset");
		end
		repeat (4)
		begin
			send_vector(1'b0, 0);
			wait_drain();
			repeat (3)
				@(negedge clk);
		end
		send_vector(1'b1, 0);
		wait_drain();
		// as fast as busy lets them in
		repeat (6)
			send_vector(1'b0, 0);
		wait_drain();
		repeat (4)
			send_vector(1'b0, 3);
		wait_drain();
		check_value(last_count, NUM_VEC, "out_last pulse count");
		if (u_dut.u_sva.fail_count != 0)
		begin
			$display("protocol assertions failed %0d times during the run",
				u_dut.u_sva.fail_count);
			$display("SOME TESTS FAILED");
			$fatal(1, "protocol assertions failed");
		end
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: sim/cg_step_sva.sv
`default_nettype none

module cg_step_sva (
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire busy,
	input wire out_valid,
	input wire out_last,
	input wire zero_div
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	a_last_with_valid: assert property (@(posedge clk) disable iff (reset)
		out_last |-> out_valid)
	else
	begin
		$error("out_last seen without out_valid");
		fail_count++;
	end

	// busy is only ever high at a vector boundary
	a_no_start_while_busy: assert property (@(posedge clk) disable iff (reset)
		in_valid |-> !busy)
	else
	begin
		$error("vector started while busy");
		fail_count++;
	end

	a_zero_div_with_valid: assert property (@(posedge clk) disable iff (reset)
		zero_div |-> out_valid)
	else
	begin
		$error("zero_div seen without out_valid");
		fail_count++;
	end

endmodule

bind cg_step_top cg_step_sva u_sva (
	.clk(clk),
	.reset(reset),
	.in_valid(in_valid),
	.busy(busy),
	.out_valid(out_valid),
	.out_last(out_last),
	.zero_div(zero_div)
);

`default_nettype wire

// File: hw/cg_step_top.sv
`default_nettype none

`include "cg_params.svh"

module cg_step_top
	import cg_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire cg_elem_t in_elem,
	output logic busy,
	output logic out_valid,
	output cg_out_t out_elem,
	output logic out_last,
	output logic zero_div
);

	logic elem_push;
	cg_elem_t elem_wdata;
	logic elem_pop;
	cg_elem_t elem_rdata;
	logic [$clog2(`CG_ELEM_DEPTH + 1)-1:0] elem_free;
	logic pair_push;
	cg_pair_t pair_wdata;
	logic pair_pop;
	cg_pair_t pair_rdata;
	logic pair_empty;

	cg_dot_producer u_producer (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_elem(in_elem),
		.elem_free(elem_free),
		.busy(busy),
		.elem_push(elem_push),
		.elem_data(elem_wdata),
		.pair_push(pair_push),
		.pair_data(pair_wdata)
	);

	// beats wait here until alpha is known
	cg_fifo #(
		.T(cg_elem_t),
		.DEPTH(`CG_ELEM_DEPTH)
	) u_elem_fifo (
		.clk(clk),
		.reset(reset),
		.push(elem_push),
		.push_data(elem_wdata),
		.pop(elem_pop),
		.pop_data(elem_rdata),
		.empty(),
		.free_count(elem_free)
	);

	cg_fifo #(
		.T(cg_pair_t),
		.DEPTH(`CG_PAIR_DEPTH)
	) u_pair_fifo (
		.clk(clk),
		.reset(reset),
		.push(pair_push),
		.push_data(pair_wdata),
		.pop(pair_pop),
		.pop_data(pair_rdata),
		.empty(pair_empty),
		.free_count()
	);

	cg_update_consumer u_consumer (
		.clk(clk),
		.reset(reset),
		.pair_empty(pair_empty),
		.pair_pop(pair_pop),
		.pair_data(pair_rdata),
		.elem_pop(elem_pop),
		.elem_data(elem_rdata),
		.out_valid(out_valid),
		.out_elem(out_elem),
		.out_last(out_last),
		.zero_div(zero_div)
	);

endmodule

`default_nettype wire

// File: hw/cg_update_consumer.sv
`default_nettype none

`include "cg_params.svh"

module cg_update_consumer
	import cg_pkg::*;
#(
	localparam int BW = $clog2(`CG_N)
)
(
	input wire clk,
	input wire reset,
	input wire pair_empty,
	output logic pair_pop,
	input wire cg_pair_t pair_data,
	output logic elem_pop,
	input wire cg_elem_t elem_data,
	output logic out_valid,
	output cg_out_t out_elem,
	output logic out_last,
	output logic zero_div
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DIVIDE,
		ST_UPDATE
	} state_t;

	state_t state;
	logic [BW-1:0] beat_cnt;
	fix_t alpha;
	acc_t div_dividend;
	fix_t div_quotient;
	logic div_zero;
	logic div_done;
	acc_t prod_p;
	acc_t prod_ap;
	acc_t step_x;
	acc_t step_r;

	// the pair is popped in the same cycle the divider starts
	assign pair_pop = (state == ST_IDLE) && !pair_empty;
	assign elem_pop = (state == ST_UPDATE);
	assign div_dividend = acc_t'(pair_data.rr) <<< `CG_FRAC;

	cg_alpha_divider u_divider (
		.clk(clk),
		.reset(reset),
		.start(pair_pop),
		.dividend(div_dividend),
		.divisor(pair_data.pap),
		.quotient(div_quotient),
		.zero_div(div_zero),
		.done(div_done)
	);

	always_comb
	begin
		prod_p = acc_t'(alpha) * acc_t'(elem_data.p);
		prod_ap = acc_t'(alpha) * acc_t'(elem_data.ap);
		step_x = prod_p >>> `CG_FRAC;
		step_r = prod_ap >>> `CG_FRAC;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			beat_cnt <= '0;
			out_valid <= 1'b0;
			out_last <= 1'b0;
			zero_div <= 1'b0;
		end
		else
		begin
			out_valid <= elem_pop;
			out_last <= elem_pop && (beat_cnt == BW'(`CG_N - 1));
			zero_div <= elem_pop && div_zero;
			case (state)
				ST_IDLE:
					if (pair_pop)
						state <= ST_DIVIDE;
				ST_DIVIDE:
					if (div_done)
					begin
						state <= ST_UPDATE;
						beat_cnt <= '0;
					end
				ST_UPDATE:
				begin
					beat_cnt <= beat_cnt + 1'b1;
					if (beat_cnt == BW'(`CG_N - 1))
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// alpha stays put for the whole vector
	always_ff @(posedge clk)
	begin
		if (div_done)
			alpha <= div_quotient;
		if (elem_pop)
		begin
			out_elem.x_new <= elem_data.x + step_x[`CG_W-1:0];
			out_elem.r_new <= elem_data.r - step_r[`CG_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: hw/cg_alpha_divider.sv
`default_nettype none

`include "cg_params.svh"

module cg_alpha_divider
	import cg_pkg::*;
#(
	localparam int QB = `CG_W + `CG_FRAC,
	localparam int CNTW = $clog2(QB + 1)
)
(
	input wire clk,
	input wire reset,
	input wire start,
	input wire acc_t dividend,
	input wire fix_t divisor,
	output fix_t quotient,
	output logic zero_div,
	output logic done
);

	logic running;
	logic [CNTW-1:0] step;
	logic negative;
	// dividend bits leave at the top, quotient bits enter at the bottom
	logic [QB-1:0] work;
	logic [`CG_W-1:0] rem;
	logic [`CG_W-1:0] mag_d;
	acc_t abs_n;
	logic [`CG_W-1:0] abs_d;
	logic [`CG_W:0] trial;
	logic [`CG_W:0] diff;
	logic fits;
	logic [QB-1:0] q_signed;

	always_comb
	begin
		abs_n = dividend[63] ? -dividend : dividend;
		abs_d = divisor[`CG_W-1] ? -divisor : divisor;
		trial = {rem, work[QB-1]};
		diff = trial - {1'b0, mag_d};
		fits = (trial >= {1'b0, mag_d});
		q_signed = negative ? -work : work;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			step <= '0;
			zero_div <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				running <= 1'b1;
				step <= '0;
				zero_div <= (divisor == '0);
			end
			else if (running)
			begin
				// one extra step applies the sign
				if (step == CNTW'(QB))
				begin
					running <= 1'b0;
					done <= 1'b1;
				end
				else
					step <= step + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			work <= abs_n[QB-1:0];
			rem <= '0;
			mag_d <= abs_d;
			negative <= dividend[63] ^ divisor[`CG_W-1];
		end
		else if (running)
		begin
			if (step == CNTW'(QB))
				quotient <= zero_div ? '0 : q_signed[`CG_W-1:0];
			else
			begin
				work <= {work[QB-2:0], fits};
				rem <= fits ? diff[`CG_W-1:0] : trial[`CG_W-1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/cg_dot_producer.sv
`default_nettype none

`include "cg_params.svh"

module cg_dot_producer
	import cg_pkg::*;
#(
	localparam int FW = $clog2(`CG_ELEM_DEPTH + 1),
	localparam int BW = $clog2(`CG_N)
)
(
	input wire clk,
	input wire reset,
	input wire in_valid,
	input wire cg_elem_t in_elem,
	input wire [FW-1:0] elem_free,
	output logic busy,
	output logic elem_push,
	output cg_elem_t elem_data,
	output logic pair_push,
	output cg_pair_t pair_data
);

	logic [BW-1:0] beat_cnt;
	logic last_beat;
	logic prod_valid;
	logic prod_first;
	logic prod_last;
	acc_t prod_rr;
	acc_t prod_pap;
	logic sum_last;
	acc_t acc_rr;
	acc_t acc_pap;
	acc_t rr_shift;
	acc_t pap_shift;

	assign last_beat = (beat_cnt == BW'(`CG_N - 1));

	// a new vector needs room for all of its beats
	assign busy = (beat_cnt == '0) && (elem_free < FW'(`CG_N));

	// every accepted beat goes straight into the element buffer
	assign elem_push = in_valid;
	assign elem_data = in_elem;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			beat_cnt <= '0;
			prod_valid <= 1'b0;
			prod_first <= 1'b0;
			prod_last <= 1'b0;
			sum_last <= 1'b0;
		end
		else
		begin
			if (in_valid)
				beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
			prod_valid <= in_valid;
			prod_first <= in_valid && (beat_cnt == '0);
			prod_last <= in_valid && last_beat;
			sum_last <= prod_valid && prod_last;
		end
	end

	// stage 1: full 64-bit products
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			prod_rr <= acc_t'(in_elem.r) * acc_t'(in_elem.r);
			prod_pap <= acc_t'(in_elem.p) * acc_t'(in_elem.ap);
		end
	end

	// stage 2: running sums, restarted by the first beat of a vector
	always_ff @(posedge clk)
	begin
		if (prod_valid)
		begin
			if (prod_first)
			begin
				acc_rr <= prod_rr;
				acc_pap <= prod_pap;
			end
			else
			begin
				acc_rr <= acc_rr + prod_rr;
				acc_pap <= acc_pap + prod_pap;
			end
		end
	end

	// back to Q16.16 once the last product has been summed
	assign rr_shift = acc_rr >>> `CG_FRAC;
	assign pap_shift = acc_pap >>> `CG_FRAC;
	assign pair_push = sum_last;
	assign pair_data.rr = rr_shift[`CG_W-1:0];
	assign pair_data.pap = pap_shift[`CG_W-1:0];

endmodule

`default_nettype wire

// File: hw/cg_fifo.sv
`default_nettype none

`include "cg_params.svh"

module cg_fifo
	import cg_pkg::*;
#(
	parameter type T = cg_elem_t,
	parameter int DEPTH = `CG_ELEM_DEPTH,
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1,
	localparam int CW = $clog2(DEPTH + 1)
)
(
	input wire clk,
	input wire reset,
	input wire push,
	input wire T push_data,
	input wire pop,
	output T pop_data,
	output logic empty,
	output logic [CW-1:0] free_count
);

	T mem [DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	assign do_push = push && (count != CW'(DEPTH));
	assign do_pop = pop && (count != '0);

	// head entry is visible without a pop
	assign pop_data = mem[rd_ptr];
	assign empty = (count == '0);
	assign free_count = CW'(DEPTH) - count;

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			// simultaneous push and pop leaves the count alone
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: hw/cg_pkg.sv
`default_nettype none

`include "cg_params.svh"

package cg_pkg;

	// signed fixed-point word
	typedef logic signed [`CG_W-1:0] fix_t;

	// wide enough for a full product and its running sum
	typedef logic signed [63:0] acc_t;

	// one input beat
	typedef struct packed {
		fix_t x;
		fix_t r;
		fix_t p;
		fix_t ap;
	} cg_elem_t;

	// finished dot products of one vector
	typedef struct packed {
		fix_t rr;
		fix_t pap;
	} cg_pair_t;

	// one output beat
	typedef struct packed {
		fix_t x_new;
		fix_t r_new;
	} cg_out_t;

endpackage

`default_nettype wire

// File: hw/cg_params.svh
`ifndef CG_PARAMS_SVH
`define CG_PARAMS_SVH

// elements per vector, one beat each
`define CG_N 8

// Q16.16 word
`define CG_W 32
`define CG_FRAC 16

// element buffer holds two whole vectors
`define CG_ELEM_DEPTH (2 * `CG_N)

// one pair per vector in flight
`define CG_PAIR_DEPTH 2

`endif
